/* Makefile */
# Verilator build for the display controller testbench

VERILATOR ?= verilator
TOP       ?= chrono_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ns

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
source/avr_bus_pkg.sv
source/video_pkg.sv
source/vram_bus_if.sv
source/mpu_bridge.sv
source/vram_arbiter.sv
source/vga_timing.sv
source/pixel_fetch.sv
source/vram_8kx16.sv
source/chrono_main.sv
verif/chrono_asserts.sv
verif/chrono_checker.sv
verif/chrono_tb.sv

/* source/avr_bus_pkg.sv */
// AVR host bus widths, host address map and control register offsets
`default_nettype none

package avr_bus_pkg;

  // Host side of the multiplexed bus
  localparam int mpu_addr_width = 16;
  localparam int mpu_data_width = 8;
  localparam int ah_width       = 8;

  // Internal bus and video RAM
  localparam int word_width      = 16;
  localparam int vram_addr_width = 13;

  // Byte addresses with this bit set land in VRAM
  // Bits 13..1 then give the word index
  localparam int vram_map_bit = 15;

  // Register word offsets below 'h8000
  // Anything else in that range reads zero and drops writes
  localparam int reg_ctrl_word  = 0;
  localparam int reg_frame_word = 1;

endpackage

`default_nettype wire

/* source/chrono_main.sv */
// Display controller top: AVR bridge, VRAM arbitration, RAM and VGA scan-out
`timescale 1ns/1ns
`default_nettype none

module chrono_main import avr_bus_pkg::*, video_pkg::*; #(
  parameter int h_active = 8,
  parameter int h_front  = 2,
  parameter int h_sync   = 2,
  parameter int h_back   = 2,
  parameter int v_active = 4,
  parameter int v_front  = 1,
  parameter int v_sync   = 1,
  parameter int v_back   = 1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mpu_rd_n,
  input  logic                      mpu_wr_n,
  input  logic                      mpu_ale,
  input  logic [ah_width-1:0]       mpu_ah,
  input  logic [mpu_data_width-1:0] mpu_ad_in,
  output logic [mpu_data_width-1:0] mpu_ad_out,
  output logic                      mpu_ad_oe,
  output logic                      hsync,
  output logic                      vsync,
  output logic [rgb_depth-1:0]      rgb
);

  logic                       pix_en;
  logic                       active;
  logic                       t_hsync;
  logic                       t_vsync;
  logic [vram_addr_width-1:0] x;
  logic [vram_addr_width-1:0] y;
  logic                       frame_start;
  logic                       display_en;
  logic                       fetch_req;
  logic [vram_addr_width-1:0] fetch_addr;
  pixel_word_t                fetch_data;

  // Host side and RAM side of the arbiter
  vram_bus_if host_port ();
  vram_bus_if ram_port ();

  mpu_bridge i_bridge (
    .clk, .rst,
    .rd_n (mpu_rd_n), .wr_n (mpu_wr_n), .ale (mpu_ale),
    .ah (mpu_ah), .ad_in (mpu_ad_in), .ad_out (mpu_ad_out), .ad_oe (mpu_ad_oe),
    .frame_start, .display_en,
    .host (host_port)
  );

  vram_arbiter i_arbiter (
    .clk, .rst,
    .fetch_req, .fetch_addr, .fetch_data,
    .host (host_port), .ram (ram_port)
  );

  vram_8kx16 i_vram (.clk, .mem (ram_port));

  vga_timing #(
    .h_active (h_active), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
    .v_active (v_active), .v_front (v_front), .v_sync (v_sync), .v_back (v_back)
  ) i_timing (
    .clk, .rst, .pix_en, .hsync (t_hsync), .vsync (t_vsync),
    .active, .x, .y, .frame_start
  );

  // Pins trail the counters by 2 clocks
  pixel_fetch #(.h_active (h_active)) i_fetch (
    .clk, .rst, .pix_en, .active,
    .hsync_in (t_hsync), .vsync_in (t_vsync), .display_en,
    .x, .y, .fetch_req, .fetch_addr, .fetch_data,
    .rgb, .hsync, .vsync
  );

endmodule

`default_nettype wire

/* source/mpu_bridge.sv */
// AVR multiplexed bus to 16-bit access port bridge with control registers
`timescale 1ns/1ns
`default_nettype none

module mpu_bridge import avr_bus_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rd_n,
  input  logic                      wr_n,
  input  logic                      ale,
  input  logic [ah_width-1:0]       ah,
  input  logic [mpu_data_width-1:0] ad_in,
  output logic [mpu_data_width-1:0] ad_out,
  output logic                      ad_oe,
  input  logic                      frame_start,
  output logic                      display_en,
  vram_bus_if.master                host
);

  localparam logic [mpu_addr_width-2:0] ctrl_off  = (mpu_addr_width-1)'(reg_ctrl_word);
  localparam logic [mpu_addr_width-2:0] frame_off = (mpu_addr_width-1)'(reg_frame_word);

  logic [mpu_data_width-1:0] al;
  logic [mpu_addr_width-1:0] byte_addr;
  logic [mpu_addr_width-2:0] reg_word;
  logic                      rd_q;
  logic                      wr_q;
  logic                      start;
  logic                      is_vram;
  logic                      odd;
  logic [word_width-1:0]     ctrl_word;
  logic [word_width-1:0]     frame_cnt;
  logic [word_width-1:0]     reg_rdata;
  logic [word_width-1:0]     rd_word;

  //////////////////////////////////////////////////
  // Address latch and decode
  //////////////////////////////////////////////////

  // Low address follows AD while ale is high, held afterwards
  always_ff @(posedge clk) begin
    if (ale) begin
      al <= ad_in;
    end
  end

  assign byte_addr = {ah, al};
  assign odd       = byte_addr[0];
  assign is_vram   = byte_addr[vram_map_bit];
  // Word offset in register space
  assign reg_word  = byte_addr[mpu_addr_width-1:1];

  // Newly low strobe, and only one of the two low
  assign start = ((!rd_n && rd_q) || (!wr_n && wr_q)) && (rd_n ^ wr_n);

  //////////////////////////////////////////////////
  // VRAM requests
  //////////////////////////////////////////////////

  assign host.en    = start && is_vram;
  assign host.rd    = !rd_n;
  assign host.wr    = !wr_n;
  // Odd byte address is the high byte
  assign host.be    = odd ? 2'b10 : 2'b01;
  assign host.addr  = byte_addr[vram_addr_width:1];
  // Byte goes out on both halves, be picks the one written
  assign host.wdata = {ad_in, ad_in};

  //////////////////////////////////////////////////
  // Control word and frame counter
  //////////////////////////////////////////////////

  always_comb begin
    reg_rdata = '0;
    if (reg_word == ctrl_off) begin
      reg_rdata = ctrl_word;
    end else if (reg_word == frame_off) begin
      reg_rdata = frame_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q      <= 1'b1;
      wr_q      <= 1'b1;
      ctrl_word <= '0;
      frame_cnt <= '0;
    end else begin
      rd_q <= rd_n;
      wr_q <= wr_n;
      if (frame_start) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
      // Byte write into the control word, frame counter is read only
      if (start && !is_vram && !wr_n && reg_word == ctrl_off) begin
        if (odd) begin
          ctrl_word[word_width-1:mpu_data_width] <= ad_in;
        end else begin
          ctrl_word[mpu_data_width-1:0] <= ad_in;
        end
      end
    end
  end

  assign display_en = ctrl_word[0];

  //////////////////////////////////////////////////
  // Read word and AD output
  //////////////////////////////////////////////////

  // Register reads land next clock, VRAM reads on ack
  always_ff @(posedge clk) begin
    if (start && !is_vram && !rd_n) begin
      rd_word <= reg_rdata;
    end else if (host.ack && !rd_n) begin
      rd_word <= host.rdata;
    end
  end

  assign ad_out = odd ? rd_word[word_width-1:mpu_data_width] : rd_word[mpu_data_width-1:0];
  // Drive AD only during a clean read phase
  assign ad_oe  = !rd_n && wr_n && !ale;

endmodule

`default_nettype wire

/* source/pixel_fetch.sv */
// Scan address generation, RGB565 expansion, blanking and sync alignment
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch import avr_bus_pkg::*, video_pkg::*; #(
  parameter int h_active = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pix_en,
  input  logic                       active,
  input  logic                       hsync_in,
  input  logic                       vsync_in,
  input  logic                       display_en,
  input  logic [vram_addr_width-1:0] x,
  input  logic [vram_addr_width-1:0] y,
  output logic                       fetch_req,
  output logic [vram_addr_width-1:0] fetch_addr,
  input  pixel_word_t                fetch_data,
  output logic [rgb_depth-1:0]       rgb,
  output logic                       hsync,
  output logic                       vsync
);

  localparam logic [vram_addr_width-1:0] line_words = vram_addr_width'(h_active);

  logic                  pix_en_d;
  logic                  hs_d;
  logic                  vs_d;
  logic                  show_d;
  logic [chan_width-1:0] r6;
  logic [chan_width-1:0] g6;
  logic [chan_width-1:0] b6;

  // One word per pixel, row major
  assign fetch_req  = pix_en && active;
  assign fetch_addr = y * line_words + x;

  // 5-bit channels repeat their top bit into the new LSB
  assign r6 = {fetch_data.rgb.r, fetch_data.rgb.r[red_width-1]};
  assign g6 = fetch_data.rgb.g;
  assign b6 = {fetch_data.rgb.b, fetch_data.rgb.b[blue_width-1]};

  //////////////////////////////////////////////////
  // Two stage output pipe
  //////////////////////////////////////////////////
  // Stage 1 on pix_en samples syncs with the request,
  // stage 2 one clock later meets the RAM data
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_en_d <= 1'b0;
      hs_d     <= 1'b1;
      vs_d     <= 1'b1;
      show_d   <= 1'b0;
      hsync    <= 1'b1;
      vsync    <= 1'b1;
      rgb      <= '0;
    end else begin
      pix_en_d <= pix_en;
      if (pix_en) begin
        hs_d   <= hsync_in;
        vs_d   <= vsync_in;
        show_d <= active && display_en;
      end
      if (pix_en_d) begin
        hsync <= hs_d;
        vsync <= vs_d;
        // Blank outside active video or when disabled
        rgb   <= show_d ? {r6, g6, b6} : '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/vga_timing.sv */
// VGA pixel divider and horizontal/vertical counters with syncs and coordinates
`timescale 1ns/1ns
`default_nettype none

module vga_timing import avr_bus_pkg::*; #(
  parameter int h_active = 8,
  parameter int h_front  = 2,
  parameter int h_sync   = 2,
  parameter int h_back   = 2,
  parameter int v_active = 4,
  parameter int v_front  = 1,
  parameter int v_sync   = 1,
  parameter int v_back   = 1
) (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       pix_en,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       active,
  output logic [vram_addr_width-1:0] x,
  output logic [vram_addr_width-1:0] y,
  output logic                       frame_start
);

  localparam int cw = vram_addr_width;
  // Line and frame order: active, front porch, sync, back porch
  localparam logic [cw-1:0] h_act_end  = cw'(h_active);
  localparam logic [cw-1:0] h_sync_beg = cw'(h_active + h_front);
  localparam logic [cw-1:0] h_sync_end = cw'(h_active + h_front + h_sync);
  localparam logic [cw-1:0] h_last_cnt = cw'(h_active + h_front + h_sync + h_back - 1);
  localparam logic [cw-1:0] v_act_end  = cw'(v_active);
  localparam logic [cw-1:0] v_sync_beg = cw'(v_active + v_front);
  localparam logic [cw-1:0] v_sync_end = cw'(v_active + v_front + v_sync);
  localparam logic [cw-1:0] v_last_cnt = cw'(v_active + v_front + v_sync + v_back - 1);

  logic          div;
  logic [cw-1:0] h_cnt;
  logic [cw-1:0] v_cnt;
  logic          h_last;
  logic          v_last;

  assign h_last = (h_cnt == h_last_cnt);
  assign v_last = (v_cnt == v_last_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      div         <= 1'b0;
      h_cnt       <= '0;
      v_cnt       <= '0;
      frame_start <= 1'b0;
    end else begin
      div         <= ~div;
      // High in the first cycle back at 0,0
      frame_start <= div && h_last && v_last;
      if (div) begin
        if (h_last) begin
          h_cnt <= '0;
          v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  assign pix_en = div;
  // Both syncs active low
  assign hsync  = !(h_cnt >= h_sync_beg && h_cnt < h_sync_end);
  assign vsync  = !(v_cnt >= v_sync_beg && v_cnt < v_sync_end);
  assign active = (h_cnt < h_act_end) && (v_cnt < v_act_end);
  assign x      = h_cnt;
  assign y      = v_cnt;

endmodule

`default_nettype wire

/* source/video_pkg.sv */
// Video colour depth, RGB565 pixel word layout and expansion widths
`default_nettype none

package video_pkg;

  // 6 bits per channel on the VGA pins
  localparam int rgb_depth  = 18;
  localparam int chan_width = 6;

  // RGB565 field widths as stored in VRAM
  localparam int red_width   = 5;
  localparam int green_width = 6;
  localparam int blue_width  = 5;

  typedef struct packed {
    logic [red_width-1:0]   r;
    logic [green_width-1:0] g;
    logic [blue_width-1:0]  b;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  // Same 16-bit word, seen as colour by the scan side
  // and as two bytes by the RAM's byte enables
  typedef union packed {
    rgb565_t    rgb;
    byte_pair_t bytes;
  } pixel_word_t;

endpackage

`default_nettype wire

/* source/vram_8kx16.sv */
// Synchronous single-port 8K x 16 video RAM with byte enables
`timescale 1ns/1ns
`default_nettype none

module vram_8kx16 import avr_bus_pkg::*, video_pkg::*; (
  input logic        clk,
  vram_bus_if.memory mem
);

  localparam int depth = 1 << vram_addr_width;

  pixel_word_t ram [0:depth-1];

  // Write only the enabled bytes
  always_ff @(posedge clk) begin
    if (mem.en && mem.wr) begin
      if (mem.be[1]) begin
        ram[mem.addr].bytes.hi <= mem.wdata.bytes.hi;
      end
      if (mem.be[0]) begin
        ram[mem.addr].bytes.lo <= mem.wdata.bytes.lo;
      end
    end
  end

  // Read data and ack one clock after en
  always_ff @(posedge clk) begin
    if (mem.en && mem.rd) begin
      mem.rdata <= ram[mem.addr];
    end
    mem.ack <= mem.en;
  end

endmodule

`default_nettype wire

/* source/vram_arbiter.sv */
// Shares the single VRAM port between scan fetch and host accesses
`timescale 1ns/1ns
`default_nettype none

module vram_arbiter import avr_bus_pkg::*, video_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_req,
  input  logic [vram_addr_width-1:0] fetch_addr,
  output pixel_word_t                fetch_data,
  vram_bus_if.memory                 host,
  vram_bus_if.master                 ram
);

  typedef enum logic [1:0] {idle, host_wait, host_issue, host_done} state_t;

  state_t                     state;
  logic                       pend_rd;
  logic                       pend_wr;
  logic [1:0]                 pend_be;
  logic [vram_addr_width-1:0] pend_addr;
  pixel_word_t                pend_wdata;
  pixel_word_t                host_rdata;
  logic                       issue_now;
  logic                       issue_pend;

  // Host goes straight through if the slot is free,
  // otherwise it waits one pixel slot at most
  assign issue_now  = (state == idle) && host.en && !fetch_req;
  assign issue_pend = (state == host_wait) && !fetch_req;

  //////////////////////////////////////////////////
  // RAM port mux, fetch first
  //////////////////////////////////////////////////
  always_comb begin
    ram.en    = fetch_req || issue_now || issue_pend;
    ram.rd    = 1'b1;
    ram.wr    = 1'b0;
    ram.be    = 2'b11;
    ram.addr  = fetch_addr;
    ram.wdata = pend_wdata;
    if (issue_now) begin
      ram.rd    = host.rd;
      ram.wr    = host.wr;
      ram.be    = host.be;
      ram.addr  = host.addr;
      ram.wdata = host.wdata;
    end else if (issue_pend) begin
      ram.rd    = pend_rd;
      ram.wr    = pend_wr;
      ram.be    = pend_be;
      ram.addr  = pend_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle:       if (host.en) state <= fetch_req ? host_wait : host_issue;
        host_wait:  if (!fetch_req) state <= host_issue;
        host_issue: state <= host_done;
        host_done:  state <= idle;
      endcase
    end
  end

  // Pending request and returned word
  always_ff @(posedge clk) begin
    if (state == idle && host.en) begin
      pend_rd    <= host.rd;
      pend_wr    <= host.wr;
      pend_be    <= host.be;
      pend_addr  <= host.addr;
      pend_wdata <= host.wdata;
    end
    if (state == host_issue && ram.ack) begin
      host_rdata <= ram.rdata;
    end
  end

  assign host.ack   = (state == host_done);
  assign host.rdata = host_rdata;
  // Fetch data is whatever the RAM answered the cycle after pix_en
  assign fetch_data = ram.rdata;

endmodule

`default_nettype wire

/* source/vram_bus_if.sv */
// One VRAM-style access port: request pulse, byte enables, data and ack
`timescale 1ns/1ns
`default_nettype none

interface vram_bus_if import avr_bus_pkg::*, video_pkg::*; ();

  // One-cycle access pulse with its type
  logic                       en;
  logic                       rd;
  logic                       wr;
  logic [1:0]                 be;
  logic [vram_addr_width-1:0] addr;
  pixel_word_t                wdata;

  // Answer side, rdata valid with ack
  pixel_word_t                rdata;
  logic                       ack;

  modport master (output en, rd, wr, be, addr, wdata, input rdata, ack);
  modport memory (input en, rd, wr, be, addr, wdata, output rdata, ack);

endinterface

`default_nettype wire

/* verif/chrono_asserts.sv */
// Bound bus and arbitration rule assertions for the display controller top
`timescale 1ns/1ns
`default_nettype none

module chrono_asserts (
  input logic clk,
  input logic rst,
  input logic ram_en,
  input logic ram_rd,
  input logic ram_wr,
  input logic host_en,
  input logic host_ack,
  input logic ad_oe,
  input logic wr_n
);

  // Clocks since the last host request, cleared by its ack
  logic [2:0] since_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      since_en <= '0;
    end else if (host_en) begin
      since_en <= 3'd1;
    end else if (host_ack) begin
      since_en <= '0;
    end else if (since_en != '0) begin
      since_en <= since_en + 3'd1;
    end
  end

  // RAM access is a read or a write, never both
  a_ram_rd_wr : assert property (@(posedge clk) disable iff (rst) ram_en |-> !(ram_rd && ram_wr))
    else $error("RAM saw rd and wr together");

  // Ack at most 3 clocks after the host request
  a_host_ack : assert property (@(posedge clk) disable iff (rst) since_en <= 3'd3)
    else $error("host ack missing 3 clocks after request");

  a_oe_wr : assert property (@(posedge clk) disable iff (rst) !(ad_oe && !wr_n))
    else $error("AD driven during a write strobe");

endmodule

bind chrono_main chrono_asserts i_asserts (
  .clk      (clk),
  .rst      (rst),
  .ram_en   (ram_port.en),
  .ram_rd   (ram_port.rd),
  .ram_wr   (ram_port.wr),
  .host_en  (host_port.en),
  .host_ack (host_port.ack),
  .ad_oe    (mpu_ad_oe),
  .wr_n     (mpu_wr_n)
);

`default_nettype wire

/* verif/chrono_checker.sv */
// Bus and video checker: mirrors host writes, predicts read bytes and pixel colours
`timescale 1ns/1ns
`default_nettype none

module chrono_checker #(
  parameter int h_active = 8,
  parameter int v_active = 4,
  parameter int h_back   = 2,
  parameter int h_front  = 2,
  parameter int h_sync   = 2,
  parameter int v_front  = 1,
  parameter int v_sync   = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        ale,
  input  logic [7:0]  ah,
  input  logic [7:0]  ad_in,
  input  logic [7:0]  ad_out,
  input  logic        ad_oe,
  input  logic        hsync,
  input  logic        vsync,
  input  logic [17:0] rgb,
  input  logic        check_pix,
  output int          errors
);

  // Pixels per line, porches and sync included
  localparam int line_pix = h_active + h_front + h_sync + h_back;

  logic [15:0] mirror [0:8191];
  logic [15:0] ctrl_m;
  logic [7:0]  al_m;
  logic [7:0]  last_frame;
  logic        prev_wr;
  logic        prev_hs;
  logic        prev_vs;
  logic        synced;
  logic        have_frame;
  int          rd_cnt;
  int          pos;
  int          ln;
  int          hs_low;
  int          vs_low;

  // RGB565 to RGB666, 5-bit channels repeat their MSB
  function automatic logic [17:0] expand565(input logic [15:0] w);
    return {w[15:11], w[15], w[10:5], w[4:0], w[4]};
  endfunction

  task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
  endtask

  initial errors = 0;

  always @(posedge clk) begin : watch
    logic [15:0] addr;
    logic [15:0] word;
    logic [7:0]  exp_b;
    logic [17:0] exp_rgb;
    int          x;
    if (rst) begin
      ctrl_m     = '0;
      prev_wr    = 1'b1;
      prev_hs    = 1'b1;
      prev_vs    = 1'b1;
      synced     = 1'b0;
      have_frame = 1'b0;
      rd_cnt     = 0;
      pos        = 0;
      ln         = -1;
      hs_low     = 0;
      vs_low     = 0;
    end else begin
      if (ale) begin
        al_m = ad_in;
      end
      addr = {ah, al_m};

      if (ad_oe !== (!rd_n && wr_n && !ale)) begin
        report("ad_oe", {31'b0, !rd_n && wr_n && !ale}, {31'b0, ad_oe});
      end

      //////////////////////////////////////////////////
      // Host writes into the mirror
      //////////////////////////////////////////////////
      if (!wr_n && prev_wr && rd_n) begin
        if (addr[15]) begin
          word = mirror[addr[13:1]];
          if (addr[0]) word[15:8] = ad_in;
          else word[7:0] = ad_in;
          mirror[addr[13:1]] = word;
        end else if (addr[15:1] == 15'd0) begin
          if (addr[0]) ctrl_m[15:8] = ad_in;
          else ctrl_m[7:0] = ad_in;
        end
      end
      prev_wr = wr_n;

      // Read byte is sampled after 6 clocks of strobe
      if (!rd_n && wr_n) rd_cnt++;
      else rd_cnt = 0;
      if (rd_cnt == 6) begin
        if (addr[15]) begin
          word  = mirror[addr[13:1]];
          exp_b = addr[0] ? word[15:8] : word[7:0];
          if (ad_out !== exp_b) report($sformatf("vram_read %h", addr), exp_b, ad_out);
        end else if (addr[15:1] == 15'd0) begin
          exp_b = addr[0] ? ctrl_m[15:8] : ctrl_m[7:0];
          if (ad_out !== exp_b) report("ctrl_read", exp_b, ad_out);
        end else if (addr[15:1] == 15'd1) begin
          if (have_frame && ad_out !== last_frame + 8'd1) begin
            report("frame_step", last_frame + 8'd1, ad_out);
          end
          have_frame = 1'b1;
          last_frame = ad_out;
        end else if (ad_out !== 8'h00) begin
          report($sformatf("unmapped_read %h", addr), 8'h00, ad_out);
        end
      end

      //////////////////////////////////////////////////
      // Sync pulse widths, line and frame length
      //////////////////////////////////////////////////
      if (hsync && !prev_hs) begin
        if (synced && hs_low != 2 * h_sync) begin
          report("hsync_width", 2 * h_sync, hs_low);
        end
        if (synced && pos + 1 != 2 * line_pix) begin
          report("line_clocks", 2 * line_pix, pos + 1);
        end
        hs_low = 0;
      end else if (!hsync) begin
        hs_low++;
      end
      if (vsync && !prev_vs) begin
        if (synced && vs_low != 2 * v_sync * line_pix) begin
          report("vsync_width", 2 * v_sync * line_pix, vs_low);
        end
        // Line count seen since the last vsync rise
        if (synced && ln != v_active + v_front + v_sync) begin
          report("frame_lines", v_active + v_front + v_sync, ln);
        end
        vs_low = 0;
      end else if (!vsync) begin
        vs_low++;
      end

      //////////////////////////////////////////////////
      // Pixel position from the sync pins
      //////////////////////////////////////////////////
      if (hsync && !prev_hs) pos = 0;
      else pos = pos + 1;
      if (vsync && !prev_vs) begin
        ln     = -1;
        synced = 1'b1;
      end else if (hsync && !prev_hs) begin
        ln = ln + 1;
      end
      prev_hs = hsync;
      prev_vs = vsync;
      // Back porch first, then the active pixels
      x       = pos / 2 - h_back;
      exp_rgb = '0;
      if (ctrl_m[0] && ln >= 0 && ln < v_active && x >= 0 && x < h_active) begin
        exp_rgb = expand565(mirror[ln * h_active + x]);
      end
      if (check_pix && synced && rgb !== exp_rgb) begin
        report($sformatf("pixel x%0d y%0d", x, ln), exp_rgb, rgb);
      end
    end
  end

endmodule

`default_nettype wire

/* verif/chrono_tb.sv */
// Display controller testbench: host bus stimulus, scan checks and final report
`timescale 1ns/1ns
`default_nettype none

module chrono_tb;

  localparam int h_active = 8;
  localparam int v_active = 4;
  localparam int h_back   = 2;
  localparam int h_front  = 2;
  localparam int h_sync   = 2;
  localparam int v_front  = 1;
  localparam int v_sync   = 1;
  localparam int frame_clks = 2 * 14 * 7;

  logic        clk;
  logic        rst;
  logic        rd_n;
  logic        wr_n;
  logic        ale;
  logic [7:0]  ah;
  logic [7:0]  ad_in;
  logic [7:0]  ad_out;
  logic        ad_oe;
  logic        hsync;
  logic        vsync;
  logic [17:0] rgb;
  logic        check_pix;
  logic [31:0] rng;
  logic [15:0] wr_addr [0:23];
  int          chk_errors;
  int          timeouts;

  chrono_main i_dut (
    .clk, .rst,
    .mpu_rd_n (rd_n), .mpu_wr_n (wr_n), .mpu_ale (ale),
    .mpu_ah (ah), .mpu_ad_in (ad_in), .mpu_ad_out (ad_out), .mpu_ad_oe (ad_oe),
    .hsync, .vsync, .rgb
  );

  chrono_checker #(
    .h_active (h_active), .v_active (v_active), .h_back (h_back),
    .h_front (h_front), .h_sync (h_sync), .v_front (v_front), .v_sync (v_sync)
  ) i_chk (
    .clk, .rst, .rd_n, .wr_n, .ale, .ah, .ad_in, .ad_out, .ad_oe,
    .hsync, .vsync, .rgb, .check_pix, .errors (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  ////////////////////////////////////////////////////
  // Host bus cycles: 2 clocks of ale, 8 of strobe
  ////////////////////////////////////////////////////
  task automatic host_cycle(input logic [15:0] addr, input logic [7:0] data, input logic write);
    @(posedge clk);
    ale   <= 1'b1;
    ah    <= addr[15:8];
    ad_in <= addr[7:0];
    @(posedge clk);
    @(posedge clk);
    ale   <= 1'b0;
    ad_in <= data;
    if (write) wr_n <= 1'b0;
    else rd_n <= 1'b0;
    repeat (8) @(posedge clk);
    wr_n <= 1'b1;
    rd_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
    host_cycle(addr, data, 1'b1);
  endtask

  task automatic host_read(input logic [15:0] addr);
    host_cycle(addr, 8'h00, 1'b0);
  endtask

  // Read strobe overlapping ale, then overlapping a write strobe
  // Register space only, AD must stay released in both overlaps
  task automatic strobe_overlap();
    @(posedge clk);
    ale   <= 1'b1;
    ah    <= 8'h00;
    ad_in <= 8'h10;
    rd_n  <= 1'b0;
    @(posedge clk);
    ale   <= 1'b0;
    @(posedge clk);
    wr_n  <= 1'b0;
    @(posedge clk);
    rd_n  <= 1'b1;
    @(posedge clk);
    wr_n  <= 1'b1;
    @(posedge clk);
  endtask

  task automatic wait_vsync_rise(input int limit);
    int   n;
    logic last;
    logic found;
    n     = 0;
    found = 1'b0;
    @(posedge clk);
    last = vsync;
    while (n < limit && !found) begin
      @(posedge clk);
      n++;
      if (vsync && !last) found = 1'b1;
      last = vsync;
    end
    if (!found) begin
      timeouts++;
      $display("timeout: vsync did not rise within %0d clocks", limit);
    end
  endtask

  initial begin
    rst       = 1'b1;
    rd_n      = 1'b1;
    wr_n      = 1'b1;
    ale       = 1'b0;
    ah        = 8'h00;
    ad_in     = 8'h00;
    check_pix = 1'b0;
    rng       = 32'h51ad3b80;
    timeouts  = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Fill words 0..63 so every byte has a known value
    for (int i = 0; i < 128; i++) begin
      rng = xorshift32(rng);
      host_write(16'h8000 | 16'(i), rng[7:0]);
    end

    // Random byte writes, then read them and their neighbours
    for (int i = 0; i < 24; i++) begin
      rng = xorshift32(rng);
      wr_addr[i] = 16'h8000 | 16'(rng[14:8] & 7'h7f);
      host_write(wr_addr[i], rng[7:0]);
    end
    for (int i = 0; i < 24; i++) begin
      host_read(wr_addr[i]);
      host_read(wr_addr[i] ^ 16'h0001);
    end

    // Display still off, rgb must stay dark for a frame
    wait_vsync_rise(2 * frame_clks);
    check_pix <= 1'b1;
    wait_vsync_rise(2 * frame_clks);
    wait_vsync_rise(2 * frame_clks);
    check_pix <= 1'b0;

    // Control word with bit 0 clear, unmapped space, frame counter
    host_write(16'h0000, 8'h5a);
    rng = xorshift32(rng);
    host_write(16'h0001, rng[7:0]);
    host_read(16'h0000);
    host_read(16'h0001);
    host_read(16'h0010);
    host_read(16'h7fff);
    wait_vsync_rise(2 * frame_clks);
    host_read(16'h0002);
    wait_vsync_rise(2 * frame_clks);
    host_read(16'h0002);

    // Output enable with ale and write strobe overlapping a read
    strobe_overlap();

    // Display on, pixel checks with host reads during scan
    host_write(16'h0000, 8'h01);
    wait_vsync_rise(2 * frame_clks);
    check_pix <= 1'b1;
    for (int i = 0; i < 30; i++) begin
      rng = xorshift32(rng);
      host_read(16'h8000 | 16'(rng[6:0]));
    end
    wait_vsync_rise(2 * frame_clks);
    wait_vsync_rise(2 * frame_clks);
    check_pix <= 1'b0;
    @(posedge clk);

    $display("errors: checker %0d, timeouts %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
